//--- compile.f
source/fe_pkg.sv
source/fetch_aligner.sv
source/instr_buffer.sv
source/decode_lane.sv
source/issue_gate.sv
source/frontend_top.sv
dv/tb_frontend.sv

//--- dv/tb_frontend.sv
module tb_frontend;

    // Cycle budget per test summed, plus slack for the drains
    localparam int TEST_CYCLES = 3 + 2 + 6 + 10 + 20 + 8 + 210;
    localparam int MARGIN      = 60;

    logic                                 clk;
    logic                                 rst_n;
    logic [fe_pkg::FETCH_WIDTH-1:0]       fetch_valid;
    logic [fe_pkg::FETCH_WIDTH-1:0][31:0] fetch_pc;
    logic [fe_pkg::FETCH_WIDTH-1:0][31:0] fetch_word;
    logic [fe_pkg::CNT_W-1:0]             issue_ready;
    logic                                 flush;
    logic                                 fetch_stall_o;
    logic [fe_pkg::ISSUE_WIDTH-1:0]       issue_valid_o;
    logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] issue_pc_o;
    logic [fe_pkg::ISSUE_WIDTH-1:0][1:0]  issue_class_o;
    logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  issue_rd_o;
    logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  issue_rs1_o;
    logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  issue_rs2_o;
    logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] issue_imm_o;

    // Reference queue, oldest entry first
    logic [31:0] ref_pc   [$];
    logic [31:0] ref_word [$];

    logic [31:0] pc_base;
    logic [31:0] lcg_state;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    frontend_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .fetch_word_i  (fetch_word),
        .issue_ready_i (issue_ready),
        .flush_i       (flush),
        .fetch_stall_o (fetch_stall_o),
        .issue_valid_o (issue_valid_o),
        .issue_pc_o    (issue_pc_o),
        .issue_class_o (issue_class_o),
        .issue_rd_o    (issue_rd_o),
        .issue_rs1_o   (issue_rs1_o),
        .issue_rs2_o   (issue_rs2_o),
        .issue_imm_o   (issue_imm_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Mostly legal opcodes, now and then a raw one
    function automatic logic [31:0] make_word(input logic [31:0] r);
        logic [6:0] opc;
        case (r[31:30])
            2'd0:    opc = fe_pkg::OPC_REG;
            2'd3:    opc = r[6:0];
            default: opc = fe_pkg::OPC_IMM;
        endcase
        return {r[29:5], opc};
    endfunction

    // Expected decode of one buffered word
    function automatic void ref_decode(input fe_pkg::instr_word_u w, output logic [1:0] cls,
                                       output logic [4:0] rd, output logic [4:0] rs1,
                                       output logic [4:0] rs2, output logic [31:0] imm);
        cls = fe_pkg::CLS_ILLEGAL;
        rd  = w.r_fmt.rd;
        rs1 = w.r_fmt.rs1;
        rs2 = w.r_fmt.rs2;
        imm = '0;
        if (w.i_fmt.opcode == fe_pkg::OPC_IMM) begin
            cls = fe_pkg::CLS_IMM;
            rs2 = '0;
            imm = 32'($signed(w.i_fmt.imm));
        end else if (w.r_fmt.opcode == fe_pkg::OPC_REG) begin
            cls = fe_pkg::CLS_REG;
        end
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_class(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input logic [fe_pkg::ISSUE_WIDTH-1:0] exp,
                              input logic [fe_pkg::ISSUE_WIDTH-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // One cycle: drive at the falling edge, check, then advance the model
    task automatic step(input logic [fe_pkg::FETCH_WIDTH-1:0] mask, input logic [31:0] w0,
                        input logic [31:0] w1, input logic [fe_pkg::CNT_W-1:0] ready,
                        input logic fl);
        int                             n;
        logic                           exp_stall;
        logic [fe_pkg::ISSUE_WIDTH-1:0] exp_mask;
        logic [1:0]                     cls;
        logic [4:0]                     rd;
        logic [4:0]                     rs1;
        logic [4:0]                     rs2;
        logic [31:0]                    imm;
        fetch_valid   = mask;
        fetch_word[0] = w0;
        fetch_word[1] = w1;
        issue_ready   = ready;
        flush         = fl;
        for (int s = 0; s < fe_pkg::FETCH_WIDTH; s++) begin
            fetch_pc[s] = pc_base + 32'(4 * s);
        end
        #2;
        // Issued lanes are the ready-limited prefix of what is buffered
        n = ref_pc.size();
        if (n > int'(ready))
            n = int'(ready);
        if (n > fe_pkg::ISSUE_WIDTH)
            n = fe_pkg::ISSUE_WIDTH;
        exp_mask  = fe_pkg::ISSUE_WIDTH'((1 << n) - 1);
        exp_stall = (fe_pkg::BUF_DEPTH - ref_pc.size()) < fe_pkg::FETCH_WIDTH;
        check_mask("issue_valid_o", exp_mask, issue_valid_o);
        check_mask("fetch_stall_o", fe_pkg::ISSUE_WIDTH'(exp_stall),
                   fe_pkg::ISSUE_WIDTH'(fetch_stall_o));
        for (int i = 0; i < fe_pkg::ISSUE_WIDTH; i++) begin
            cls = fe_pkg::CLS_NONE;
            if (i < ref_pc.size())
                ref_decode(ref_word[i], cls, rd, rs1, rs2, imm);
            check_class($sformatf("issue_class_o[%0d]", i), cls, issue_class_o[i]);
            if (i < n) begin
                check_word($sformatf("issue_pc_o[%0d]", i), ref_pc[i], issue_pc_o[i]);
                check_reg($sformatf("issue_rd_o[%0d]", i), rd, issue_rd_o[i]);
                check_reg($sformatf("issue_rs1_o[%0d]", i), rs1, issue_rs1_o[i]);
                check_reg($sformatf("issue_rs2_o[%0d]", i), rs2, issue_rs2_o[i]);
                check_word($sformatf("issue_imm_o[%0d]", i), imm, issue_imm_o[i]);
            end
        end
        if (fl) begin
            ref_pc.delete();
            ref_word.delete();
        end else begin
            repeat (n) begin
                void'(ref_pc.pop_front());
                void'(ref_word.pop_front());
            end
            for (int s = 0; s < fe_pkg::FETCH_WIDTH; s++) begin
                if (mask[s]) begin
                    ref_pc.push_back(fetch_pc[s]);
                    ref_word.push_back(fetch_word[s]);
                end
            end
        end
        pc_base = pc_base + 32'(4 * fe_pkg::FETCH_WIDTH);
        @(negedge clk);
    endtask

    task automatic drain();
        while (ref_pc.size() != 0)
            step('0, '0, '0, fe_pkg::CNT_W'(fe_pkg::ISSUE_WIDTH), 1'b0);
    endtask

    task automatic report_result(input string name, input int start);
        if (errors == start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, errors - start);
        end
    endtask

    task automatic after_reset();
        int start;
        start = errors;
        step('0, '0, '0, fe_pkg::CNT_W'(2), 1'b0);
        report_result("after_reset", start);
    endtask

    task automatic decode_formats();
        int start;
        start = errors;
        // sub x3,x1,x2 and addi x5,x6,-7
        step(2'b11, {7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3, fe_pkg::OPC_REG},
             {12'hff9, 5'd6, 3'b000, 5'd5, fe_pkg::OPC_IMM}, '0, 1'b0);
        // Largest positive immediate, then a branch opcode
        step(2'b11, {12'h7ff, 5'd31, 3'b111, 5'd10, fe_pkg::OPC_IMM},
             {7'd5, 5'd9, 5'd8, 3'b001, 5'd4, 7'b1100011}, fe_pkg::CNT_W'(1), 1'b0);
        drain();
        report_result("decode_formats", start);
    endtask

    task automatic sparse_mask();
        int start;
        start = errors;
        step(2'b10, '0, make_word(lcg_next()), '0, 1'b0);
        step(2'b01, make_word(lcg_next()), '0, fe_pkg::CNT_W'(1), 1'b0);
        step(2'b11, make_word(lcg_next()), make_word(lcg_next()), fe_pkg::CNT_W'(1), 1'b0);
        step(2'b10, '0, make_word(lcg_next()), fe_pkg::CNT_W'(2), 1'b0);
        drain();
        report_result("sparse_mask", start);
    endtask

    task automatic back_pressure();
        int start;
        start = errors;
        repeat (fe_pkg::BUF_DEPTH / fe_pkg::FETCH_WIDTH)
            step(2'b11, make_word(lcg_next()), make_word(lcg_next()), '0, 1'b0);
        // Buffer full, stall must be up
        step('0, '0, '0, '0, 1'b0);
        repeat (fe_pkg::BUF_DEPTH)
            step('0, '0, '0, fe_pkg::CNT_W'(1), 1'b0);
        drain();
        report_result("back_pressure", start);
    endtask

    task automatic flush_refill();
        int start;
        start = errors;
        step(2'b11, make_word(lcg_next()), make_word(lcg_next()), '0, 1'b0);
        step(2'b11, make_word(lcg_next()), make_word(lcg_next()), fe_pkg::CNT_W'(1), 1'b1);
        step('0, '0, '0, fe_pkg::CNT_W'(2), 1'b0);
        step(2'b11, make_word(lcg_next()), make_word(lcg_next()), '0, 1'b0);
        drain();
        report_result("flush_refill", start);
    endtask

    task automatic random_stream();
        int                             start;
        logic [31:0]                    r;
        logic [fe_pkg::FETCH_WIDTH-1:0] mask;
        start = errors;
        for (int c = 0; c < 200; c++) begin
            r    = lcg_next();
            mask = r[17:16];
            // Source holds off while a full packet would not fit
            if ((fe_pkg::BUF_DEPTH - ref_pc.size()) < fe_pkg::FETCH_WIDTH)
                mask = '0;
            step(mask, make_word(lcg_next()), make_word(lcg_next()),
                 fe_pkg::CNT_W'(int'(r[25:24]) % 3), 1'b0);
        end
        drain();
        report_result("random_stream", start);
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN) * 8);
        $display("timeout: tests did not finish within their cycle budget");
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        fetch_valid  = '0;
        fetch_pc     = '0;
        fetch_word   = '0;
        issue_ready  = '0;
        flush        = 1'b0;
        pc_base      = 32'h0000_1000;
        lcg_state    = 32'd37267;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        after_reset();
        decode_formats();
        sparse_mask();
        back_pressure();
        flush_refill();
        random_stream();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f compile.f --top-module tb_frontend -o sim_frontend \
    && ./obj_dir/sim_frontend | tee /dev/stderr | grep -qx "sim passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }

//--- source/decode_lane.sv
module decode_lane (
    input  logic                head_valid_i,
    input  fe_pkg::instr_word_u head_word_i,
    output logic [1:0]          dec_class_o,
    output logic [4:0]          dec_rd_o,
    output logic [4:0]          dec_rs1_o,
    output logic [4:0]          dec_rs2_o,
    output logic [31:0]         dec_imm_o
);

    // Sign-extended I-type immediate
    logic [31:0] imm_sext;

    assign imm_sext = {{20{head_word_i.i_fmt.imm[11]}}, head_word_i.i_fmt.imm};

    always_comb begin
        // Empty lane reports nothing
        dec_class_o = fe_pkg::CLS_NONE;
        dec_rd_o    = '0;
        dec_rs1_o   = '0;
        dec_rs2_o   = '0;
        dec_imm_o   = '0;

        if (head_valid_i) begin
            // Opcode field is shared by both views
            case (head_word_i.r_fmt.opcode)
                fe_pkg::OPC_REG: begin
                    dec_class_o = fe_pkg::CLS_REG;
                    dec_rd_o    = head_word_i.r_fmt.rd;
                    dec_rs1_o   = head_word_i.r_fmt.rs1;
                    dec_rs2_o   = head_word_i.r_fmt.rs2;
                end
                fe_pkg::OPC_IMM: begin
                    dec_class_o = fe_pkg::CLS_IMM;
                    dec_rd_o    = head_word_i.i_fmt.rd;
                    dec_rs1_o   = head_word_i.i_fmt.rs1;
                    dec_imm_o   = imm_sext;
                end
                default: begin
                    // Unknown op, fields from register view so downstream can trap
                    dec_class_o = fe_pkg::CLS_ILLEGAL;
                    dec_rd_o    = head_word_i.r_fmt.rd;
                    dec_rs1_o   = head_word_i.r_fmt.rs1;
                    dec_rs2_o   = head_word_i.r_fmt.rs2;
                end
            endcase
        end
    end

endmodule

//--- source/fe_pkg.sv
package fe_pkg;

    // Frontend widths
    localparam int FETCH_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;

    // Instruction buffer geometry
    localparam int BUF_DEPTH = 8;
    localparam int PTR_W     = $clog2(BUF_DEPTH);
    localparam int CNT_W     = PTR_W + 1;

    // Recognised major opcodes
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    // Op class reported per decode lane
    localparam logic [1:0] CLS_NONE    = 2'd0;
    localparam logic [1:0] CLS_REG     = 2'd1;
    localparam logic [1:0] CLS_IMM     = 2'd2;
    localparam logic [1:0] CLS_ILLEGAL = 2'd3;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Register-immediate layout, imm sits where funct7/rs2 were
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Same 32-bit word, two readings
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

endpackage

//--- source/fetch_aligner.sv
module fetch_aligner (
    input  logic [fe_pkg::FETCH_WIDTH-1:0]       fetch_valid_i,
    input  logic [fe_pkg::FETCH_WIDTH-1:0][31:0] fetch_pc_i,
    input  logic [fe_pkg::FETCH_WIDTH-1:0][31:0] fetch_word_i,
    output logic [fe_pkg::FETCH_WIDTH-1:0][31:0] aln_pc_o,
    output logic [fe_pkg::FETCH_WIDTH-1:0][31:0] aln_word_o,
    output logic [fe_pkg::CNT_W-1:0]             aln_count_o
);

    // Next free output lane while walking the slots
    logic [fe_pkg::CNT_W-1:0] lane;

    // Compaction: k-th valid slot lands in lane k
    always_comb begin
        lane       = '0;
        aln_pc_o   = '0;
        aln_word_o = '0;
        for (int s = 0; s < fe_pkg::FETCH_WIDTH; s++) begin
            if (fetch_valid_i[s]) begin
                aln_pc_o[lane]   = fetch_pc_i[s];
                aln_word_o[lane] = fetch_word_i[s];
                lane             = lane + 1'b1;
            end
        end
        // After the walk, lane equals the popcount of the mask
        aln_count_o = lane;
    end

endmodule

//--- source/frontend_top.sv
module frontend_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [fe_pkg::FETCH_WIDTH-1:0]       fetch_valid_i,
    input  logic [fe_pkg::FETCH_WIDTH-1:0][31:0] fetch_pc_i,
    input  logic [fe_pkg::FETCH_WIDTH-1:0][31:0] fetch_word_i,
    input  logic [fe_pkg::CNT_W-1:0]             issue_ready_i,
    input  logic                                 flush_i,
    output logic                                 fetch_stall_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0]       issue_valid_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] issue_pc_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0][1:0]  issue_class_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  issue_rd_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  issue_rs1_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  issue_rs2_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] issue_imm_o
);

    // Aligner to buffer
    logic [fe_pkg::FETCH_WIDTH-1:0][31:0] aln_pc;
    logic [fe_pkg::FETCH_WIDTH-1:0][31:0] aln_word;
    logic [fe_pkg::CNT_W-1:0]             aln_count;

    // Buffer head window
    logic [fe_pkg::ISSUE_WIDTH-1:0]       head_valid;
    logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] head_pc;
    logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] head_word;

    // Decode results
    logic [fe_pkg::ISSUE_WIDTH-1:0][1:0]  dec_class;
    logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  dec_rd;
    logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  dec_rs1;
    logic [fe_pkg::ISSUE_WIDTH-1:0][4:0]  dec_rs2;
    logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] dec_imm;

    logic [fe_pkg::CNT_W-1:0]             take_count;

    fetch_aligner u_aligner (
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_word_i  (fetch_word_i),
        .aln_pc_o      (aln_pc),
        .aln_word_o    (aln_word),
        .aln_count_o   (aln_count)
    );

    instr_buffer u_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .aln_pc_i      (aln_pc),
        .aln_word_i    (aln_word),
        .aln_count_i   (aln_count),
        .take_count_i  (take_count),
        .fetch_stall_o (fetch_stall_o),
        .head_valid_o  (head_valid),
        .head_pc_o     (head_pc),
        .head_word_o   (head_word)
    );

    // One decoder per issue lane
    for (genvar i = 0; i < fe_pkg::ISSUE_WIDTH; i++) begin : g_lane
        decode_lane u_lane (
            .head_valid_i (head_valid[i]),
            .head_word_i  (head_word[i]),
            .dec_class_o  (dec_class[i]),
            .dec_rd_o     (dec_rd[i]),
            .dec_rs1_o    (dec_rs1[i]),
            .dec_rs2_o    (dec_rs2[i]),
            .dec_imm_o    (dec_imm[i])
        );
    end

    issue_gate u_gate (
        .issue_ready_i (issue_ready_i),
        .dec_class_i   (dec_class),
        .issue_valid_o (issue_valid_o),
        .take_count_o  (take_count)
    );

    // Decode fields go straight out, qualified by issue_valid_o
    assign issue_pc_o    = head_pc;
    assign issue_class_o = dec_class;
    assign issue_rd_o    = dec_rd;
    assign issue_rs1_o   = dec_rs1;
    assign issue_rs2_o   = dec_rs2;
    assign issue_imm_o   = dec_imm;

endmodule

//--- source/instr_buffer.sv
module instr_buffer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush_i,

    // From fetch aligner, valid lanes contiguous from lane 0
    input  logic [fe_pkg::FETCH_WIDTH-1:0][31:0] aln_pc_i,
    input  logic [fe_pkg::FETCH_WIDTH-1:0][31:0] aln_word_i,
    input  logic [fe_pkg::CNT_W-1:0]             aln_count_i,

    // From issue gate
    input  logic [fe_pkg::CNT_W-1:0]             take_count_i,

    output logic                                 fetch_stall_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0]       head_valid_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] head_pc_o,
    output logic [fe_pkg::ISSUE_WIDTH-1:0][31:0] head_word_o
);

    // Entry storage
    logic [31:0] pc_mem   [fe_pkg::BUF_DEPTH];
    logic [31:0] word_mem [fe_pkg::BUF_DEPTH];

    logic [fe_pkg::PTR_W-1:0] rd_ptr;
    logic [fe_pkg::PTR_W-1:0] wr_ptr;
    logic [fe_pkg::CNT_W-1:0] occupancy;
    logic [fe_pkg::CNT_W-1:0] free_cnt;

    // Per-lane wrapped addresses
    logic [fe_pkg::PTR_W-1:0] wr_idx [fe_pkg::FETCH_WIDTH];
    logic [fe_pkg::PTR_W-1:0] rd_idx [fe_pkg::ISSUE_WIDTH];

    always_comb begin
        for (int i = 0; i < fe_pkg::FETCH_WIDTH; i++) begin
            wr_idx[i] = wr_ptr + fe_pkg::PTR_W'(i);
        end
        for (int i = 0; i < fe_pkg::ISSUE_WIDTH; i++) begin
            rd_idx[i] = rd_ptr + fe_pkg::PTR_W'(i);
        end
    end

    // Stall only from registered occupancy, never from this cycle's inputs
    assign free_cnt      = fe_pkg::CNT_W'(fe_pkg::BUF_DEPTH) - occupancy;
    assign fetch_stall_o = free_cnt < fe_pkg::CNT_W'(fe_pkg::FETCH_WIDTH);

    // Payload write, no reset on storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < fe_pkg::FETCH_WIDTH; i++) begin
            if (!flush_i && (fe_pkg::CNT_W'(i) < aln_count_i)) begin
                pc_mem[wr_idx[i]]   <= aln_pc_i[i];
                word_mem[wr_idx[i]] <= aln_word_i[i];
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            occupancy <= '0;
        end else if (flush_i) begin
            // Drop everything, this cycle's writes and takes included
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            occupancy <= '0;
        end else begin
            wr_ptr    <= wr_ptr + aln_count_i[fe_pkg::PTR_W-1:0];
            rd_ptr    <= rd_ptr + take_count_i[fe_pkg::PTR_W-1:0];
            occupancy <= occupancy + aln_count_i - take_count_i;
        end
    end

    // Head window read-out
    always_comb begin
        for (int i = 0; i < fe_pkg::ISSUE_WIDTH; i++) begin
            head_valid_o[i] = fe_pkg::CNT_W'(i) < occupancy;
            head_pc_o[i]    = pc_mem[rd_idx[i]];
            head_word_o[i]  = word_mem[rd_idx[i]];
        end
    end

    // Count can never run past the storage
    a_occ_bound: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= fe_pkg::CNT_W'(fe_pkg::BUF_DEPTH));

    // Issue gate only takes what the head window showed
    a_take_bound: assert property (@(posedge clk) disable iff (!rst_n)
        take_count_i <= occupancy);

    // Fetch source must honour the stall
    a_no_write_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_stall_o |-> (aln_count_i == '0));

endmodule

//--- source/issue_gate.sv
module issue_gate (
    input  logic [fe_pkg::CNT_W-1:0]            issue_ready_i,
    input  logic [fe_pkg::ISSUE_WIDTH-1:0][1:0] dec_class_i,
    output logic [fe_pkg::ISSUE_WIDTH-1:0]      issue_valid_o,
    output logic [fe_pkg::CNT_W-1:0]            take_count_o
);

    // Stays high while every lane so far may issue
    logic in_prefix;

    always_comb begin
        in_prefix    = 1'b1;
        take_count_o = '0;
        for (int i = 0; i < fe_pkg::ISSUE_WIDTH; i++) begin
            // Illegal lanes go out like legal ones
            // Only an empty lane ends the run
            in_prefix = in_prefix
                        && (dec_class_i[i] != fe_pkg::CLS_NONE)
                        && (fe_pkg::CNT_W'(i) < issue_ready_i);
            issue_valid_o[i] = in_prefix;
            if (in_prefix) begin
                take_count_o = take_count_o + 1'b1;
            end
        end
    end

endmodule
